// File: glue_pkg.sv
/* Platform glue shared definitions
   Bus widths, descriptor structs, sequencer states and clock tables */
package glue_pkg;

	// ============================================================
	// Vector types
	// ============================================================
	typedef logic [15:0] mgmt_addr_t;
	typedef logic [31:0] mgmt_data_t;
	typedef logic [2:0]  speed_sel_t;
	typedef logic [5:0]  cfg_addr_t;
	typedef logic [31:0] cfg_data_t;
	typedef logic [31:0] rate_t;

	// ============================================================
	// Structs
	// ============================================================
	typedef struct packed {
		logic       rd;
		logic       wr;
		mgmt_addr_t addr;
		mgmt_data_t data;
	} host_cmd_t;

	// Video mode registers as delivered by the VGA core
	typedef struct packed {
		logic [19:0] start_addr;
		logic [8:0]  width;
		logic [8:0]  stride;
		logic [10:0] height;
		logic [3:0]  flags;
		logic        off;
	} vga_mode_t;

	typedef struct packed {
		logic        en;
		logic [4:0]  format;
		logic [11:0] width;
		logic [11:0] height;
		logic [31:0] base;
		logic [13:0] stride;
		logic        force_blank;
	} fb_desc_t;

	// Each write state is followed by a one-cycle gap state
	typedef enum logic [2:0] {
		IDLE, MODE, MODE_GAP, DIV, DIV_GAP, UART, UART_GAP, START
	} speed_seq_e;

	// ============================================================
	// Clock generator constants
	// ============================================================
	localparam int NUM_SPEEDS = 5;

	// 90, 100, 15, 30 and 56.25 MHz
	localparam rate_t CLK_RATE_TABLE [0:NUM_SPEEDS-1] = '{
		32'd90_000_000, 32'd100_000_000, 32'd15_000_000,
		32'd30_000_000, 32'd56_250_000
	};

	localparam cfg_data_t SPEED_DIV_TABLE [0:NUM_SPEEDS-1] = '{
		32'h0000_0505, 32'h0002_0504, 32'h0000_1e1e,
		32'h0000_0f0f, 32'h0000_0808
	};

	localparam cfg_addr_t CFG_ADDR_MODE    = 6'd0;
	localparam cfg_addr_t CFG_ADDR_COUNTER = 6'd5;
	localparam cfg_addr_t CFG_ADDR_START   = 6'd2;

	localparam cfg_data_t UART_DIV_FAST   = 32'h0004_0909;
	localparam cfg_data_t UART_DIV_NORMAL = 32'h0004_f4f4;

	// Framebuffer and misc
	localparam logic [9:0]  FB_BASE_PREFIX  = 10'h0fe;
	localparam logic [2:0]  FMT_8BPP        = 3'd3;
	localparam logic [2:0]  FMT_16BPP       = 3'd4;
	localparam logic [2:0]  FMT_24BPP       = 3'd5;
	localparam logic [11:0] FB_24BPP_WIDTH  = 12'd640;
	localparam int          RESET_PULSE_LEN = 8;
	localparam int          LED_HOLD_CYCLES = 4_500_000;

endpackage

// File: host_mgmt_bridge.sv
/* Host management bridge
   Turns host commands into single management bus transfers with wait handling */
module host_mgmt_bridge (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  glue_pkg::host_cmd_t   host_cmd,
	input  logic                  host_cmd_valid,
	output logic                  host_cmd_ready,
	output logic                  rsp_valid,
	output glue_pkg::mgmt_data_t  rsp_data,
	output logic                  bus_rd,
	output logic                  bus_wr,
	output glue_pkg::mgmt_addr_t  bus_addr,
	output glue_pkg::mgmt_data_t  bus_wdata,
	input  logic                  bus_wait,
	input  logic                  bus_rdvalid,
	input  glue_pkg::mgmt_data_t  bus_rdata
);

	logic xfer_open;
	logic xfer_is_rd;
	logic accept;
	logic wr_done;
	logic rd_done;

	assign host_cmd_ready = ~xfer_open;
	assign accept = host_cmd_valid & host_cmd_ready;

	// Write ends with the strobe released, read ends with returned data
	assign wr_done = bus_wr & ~bus_wait;
	assign rd_done = xfer_open & xfer_is_rd & bus_rdvalid;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			xfer_open <= 1'b0;
			bus_rd    <= 1'b0;
			bus_wr    <= 1'b0;
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= 1'b0;
			if (accept) begin
				// A command with neither bit set is simply dropped
				xfer_open <= host_cmd.rd | host_cmd.wr;
				bus_rd    <= host_cmd.rd;
				bus_wr    <= host_cmd.wr & ~host_cmd.rd;
			end else begin
				if (!bus_wait) begin
					bus_rd <= 1'b0;
					bus_wr <= 1'b0;
				end
				if (wr_done || rd_done) begin
					xfer_open <= 1'b0;
					rsp_valid <= 1'b1;
				end
			end
		end
	end

	// Command payload and read data capture
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			bus_addr   <= host_cmd.addr;
			bus_wdata  <= host_cmd.data;
			xfer_is_rd <= host_cmd.rd;
		end
		if (rd_done)
			rsp_data <= bus_rdata;
	end

	a_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (RESET)
		!(bus_rd && bus_wr));

endmodule

// File: reset_ctrl.sv
/* Reset controller
   Builds the system reset pulse and the combined CPU reset */
module reset_ctrl (
	input  logic clk_sys,
	input  logic RESET,
	input  logic host_reset,
	input  logic user_button,
	input  logic kbc_reset_n,
	output logic sys_reset,
	output logic cpu_reset
);

	logic                                  host_q1;
	logic                                  host_q2;
	logic [glue_pkg::RESET_PULSE_LEN-1:0]  pulse_sr;
	logic                                  init_done;
	logic                                  cpu_req;
	logic                                  host_rise;

	assign host_rise = host_q1 & ~host_q2;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			host_q1   <= 1'b0;
			host_q2   <= 1'b0;
			pulse_sr  <= '0;
			init_done <= 1'b0;
			cpu_req   <= 1'b0;
			sys_reset <= 1'b1;
			cpu_reset <= 1'b1;
		end else begin
			host_q1 <= host_reset;
			host_q2 <= host_q1;

			// Fill with ones on the edge, then shift them out
			if (host_rise) begin
				pulse_sr  <= '1;
				init_done <= 1'b1;
			end else begin
				pulse_sr <= pulse_sr << 1;
			end

			sys_reset <= ~init_done | pulse_sr[glue_pkg::RESET_PULSE_LEN-1];
			cpu_req   <= user_button | host_reset | ~kbc_reset_n;
			cpu_reset <= sys_reset | cpu_req;
		end
	end

	a_cpu_follows_sys: assert property (@(posedge clk_sys) disable iff (RESET)
		sys_reset |=> cpu_reset);

endmodule

// File: clk_speed_seq.sv
/* Clock speed sequencer
   Reprograms the clock generator with four config writes on a speed change */
module clk_speed_seq (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  glue_pkg::speed_sel_t  speed,
	input  logic                  uart_fast,
	input  logic                  cfg_wait,
	output logic                  cfg_write,
	output glue_pkg::cfg_addr_t   cfg_addr,
	output glue_pkg::cfg_data_t   cfg_data,
	output logic                  seq_busy,
	output glue_pkg::rate_t       cur_rate
);

	glue_pkg::speed_seq_e  state;
	glue_pkg::speed_sel_t  speed_q;
	glue_pkg::speed_sel_t  speed_idx;
	glue_pkg::speed_sel_t  last_speed;
	logic                  uart_q;
	logic                  last_uart;
	logic                  changed;
	logic                  taken;

	// Out of range selections fall back to the first entry
	assign speed_idx = (speed_q >= 3'(glue_pkg::NUM_SPEEDS)) ? '0 : speed_q;
	assign cur_rate  = glue_pkg::CLK_RATE_TABLE[speed_idx];
	assign changed   = (speed_idx != last_speed) || (uart_q != last_uart);
	assign taken     = cfg_write & ~cfg_wait;
	assign seq_busy  = (state != glue_pkg::IDLE);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			speed_q <= '0;
			uart_q  <= 1'b0;
		end else begin
			speed_q <= speed;
			uart_q  <= uart_fast;
		end
	end

	// ============================================================
	// Write sequence
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state      <= glue_pkg::IDLE;
			cfg_write  <= 1'b0;
			last_speed <= '0;
			last_uart  <= 1'b0;
		end else begin
			case (state)
				glue_pkg::IDLE: if (changed) begin
					last_speed <= speed_idx;
					last_uart  <= uart_q;
					cfg_write  <= 1'b1;
					cfg_addr   <= glue_pkg::CFG_ADDR_MODE;
					cfg_data   <= '0;
					state      <= glue_pkg::MODE;
				end
				glue_pkg::MODE_GAP: begin
					cfg_write <= 1'b1;
					cfg_addr  <= glue_pkg::CFG_ADDR_COUNTER;
					cfg_data  <= glue_pkg::SPEED_DIV_TABLE[last_speed];
					state     <= glue_pkg::DIV;
				end
				glue_pkg::DIV_GAP: begin
					cfg_write <= 1'b1;
					cfg_addr  <= glue_pkg::CFG_ADDR_COUNTER;
					cfg_data  <= last_uart ? glue_pkg::UART_DIV_FAST : glue_pkg::UART_DIV_NORMAL;
					state     <= glue_pkg::UART;
				end
				glue_pkg::UART_GAP: begin
					cfg_write <= 1'b1;
					cfg_addr  <= glue_pkg::CFG_ADDR_START;
					cfg_data  <= '0;
					state     <= glue_pkg::START;
				end
				default: if (taken) begin
					// Write states: hold until the port takes the word
					cfg_write <= 1'b0;
					case (state)
						glue_pkg::MODE: state <= glue_pkg::MODE_GAP;
						glue_pkg::DIV:  state <= glue_pkg::DIV_GAP;
						glue_pkg::UART: state <= glue_pkg::UART_GAP;
						default:        state <= glue_pkg::IDLE;
					endcase
				end
			endcase
		end
	end

	a_cfg_stable: assert property (@(posedge clk_sys) disable iff (RESET)
		(cfg_write && cfg_wait) |=> (cfg_write && $stable(cfg_addr) && $stable(cfg_data)));

endmodule

// File: fb_desc_gen.sv
/* Framebuffer descriptor generator
   Derives base, geometry and pixel format from the video mode registers */
module fb_desc_gen (
	input  logic                 clk_sys,
	input  glue_pkg::vga_mode_t  vga_mode,
	input  logic                 rgb_order,
	input  logic                 fmt_565,
	output glue_pkg::fb_desc_t   fb_desc
);

	logic [1:0]  depth;
	logic        planar;
	logic        dbl_scan;
	logic [2:0]  fmt_low;
	logic [11:0] width_px;
	logic [11:0] height_px;

	assign depth    = vga_mode.flags[1:0];
	assign planar   = vga_mode.flags[2];
	assign dbl_scan = vga_mode.flags[3];

	// Depth 3 is 24bpp, 2 is 16bpp, rest is paletted
	always_comb begin
		case (depth)
			2'd3:    fmt_low = glue_pkg::FMT_24BPP;
			2'd2:    fmt_low = glue_pkg::FMT_16BPP;
			default: fmt_low = glue_pkg::FMT_8BPP;
		endcase
	end

	// 24bpp width is fixed, the register counts in 3-byte units
	always_comb begin
		if (depth == 2'd3)
			width_px = glue_pkg::FB_24BPP_WIDTH;
		else if (planar)
			width_px = {1'b0, vga_mode.width, 2'b00};
		else
			width_px = {vga_mode.width, 3'b000};
	end

	assign height_px = dbl_scan ? {2'b00, vga_mode.height[10:1]} : {1'b0, vga_mode.height};

	always_ff @(posedge clk_sys) begin
		fb_desc.en          <= ~planar & (depth != 2'd0);
		fb_desc.format      <= {~rgb_order, ~fmt_565, fmt_low};
		fb_desc.width       <= width_px;
		fb_desc.height      <= height_px;
		fb_desc.base        <= {glue_pkg::FB_BASE_PREFIX, vga_mode.start_addr, 2'b00};
		fb_desc.stride      <= {2'b00, vga_mode.stride, 3'b000};
		fb_desc.force_blank <= 1'b0;
	end

endmodule

// File: activity_led.sv
/* Activity light
   Stretches short request pulses into a visible light */
module activity_led #(
	parameter int HOLD_CYCLES = glue_pkg::LED_HOLD_CYCLES
) (
	input  logic clk_sys,
	input  logic RESET,
	input  logic activity,
	output logic led
);

	localparam int CNT_W = $clog2(HOLD_CYCLES + 1);

	logic [CNT_W-1:0] hold_cnt;

	// Light is on while any hold time is left
	assign led = (hold_cnt != '0);

	always_ff @(posedge clk_sys) begin
		if (RESET)
			hold_cnt <= '0;
		else if (activity)
			hold_cnt <= CNT_W'(HOLD_CYCLES);
		else if (hold_cnt != '0)
			hold_cnt <= hold_cnt - 1'b1;
	end

endmodule

// File: ao486_glue_top.sv
/* ao486 platform glue
   Management bridge, resets, clock reprogramming, framebuffer and disk lights */
module ao486_glue_top #(
	parameter int LED_HOLD = glue_pkg::LED_HOLD_CYCLES
) (
	input  logic                  clk_sys,
	input  logic                  RESET,

	// Host command and response
	input  glue_pkg::host_cmd_t   host_cmd,
	input  logic                  host_cmd_valid,
	output logic                  host_cmd_ready,
	output logic                  rsp_valid,
	output glue_pkg::mgmt_data_t  rsp_data,

	// Core management bus
	output logic                  bus_rd,
	output logic                  bus_wr,
	output glue_pkg::mgmt_addr_t  bus_addr,
	output glue_pkg::mgmt_data_t  bus_wdata,
	input  logic                  bus_wait,
	input  logic                  bus_rdvalid,
	input  glue_pkg::mgmt_data_t  bus_rdata,

	// Reset sources and outputs
	input  logic                  host_reset,
	input  logic                  user_button,
	input  logic                  kbc_reset_n,
	output logic                  sys_reset,
	output logic                  cpu_reset,

	// Clock generator config port
	input  glue_pkg::speed_sel_t  speed,
	input  logic                  uart_fast,
	input  logic                  cfg_wait,
	output logic                  cfg_write,
	output glue_pkg::cfg_addr_t   cfg_addr,
	output glue_pkg::cfg_data_t   cfg_data,
	output logic                  seq_busy,
	output glue_pkg::rate_t       cur_rate,

	// Video
	input  glue_pkg::vga_mode_t   vga_mode,
	input  logic                  rgb_order,
	input  logic                  fmt_565,
	output glue_pkg::fb_desc_t    fb_desc,

	// Disk activity
	input  logic [7:0]            disk_req,
	output logic                  led_hdd,
	output logic                  led_fdd
);

	host_mgmt_bridge u_bridge (
		.clk_sys, .RESET,
		.host_cmd, .host_cmd_valid, .host_cmd_ready,
		.rsp_valid, .rsp_data,
		.bus_rd, .bus_wr, .bus_addr, .bus_wdata,
		.bus_wait, .bus_rdvalid, .bus_rdata
	);

	reset_ctrl u_reset (
		.clk_sys, .RESET,
		.host_reset, .user_button, .kbc_reset_n,
		.sys_reset, .cpu_reset
	);

	clk_speed_seq u_speed (
		.clk_sys, .RESET,
		.speed, .uart_fast, .cfg_wait,
		.cfg_write, .cfg_addr, .cfg_data,
		.seq_busy, .cur_rate
	);

	fb_desc_gen u_fb (
		.clk_sys, .vga_mode, .rgb_order, .fmt_565, .fb_desc
	);

	// Bits 5:0 are the two hard disks, 7:6 the floppy
	activity_led #(.HOLD_CYCLES(LED_HOLD)) u_hdd_led (
		.clk_sys, .RESET, .activity(|disk_req[5:0]), .led(led_hdd)
	);

	activity_led #(.HOLD_CYCLES(LED_HOLD)) u_fdd_led (
		.clk_sys, .RESET, .activity(|disk_req[7:6]), .led(led_fdd)
	);

endmodule

// File: tb_glue_checks.svh
/* Testbench checks
   Reference models, concurrent bus checks and result counters */
`ifndef TB_GLUE_CHECKS_SVH
`define TB_GLUE_CHECKS_SVH

	int                   err_cnt = 0;
	int                   test_cnt = 0;
	glue_pkg::mgmt_addr_t exp_addr;
	glue_pkg::mgmt_data_t exp_wdata;

	// Value the bus model returns for a read of addr
	function automatic glue_pkg::mgmt_data_t rd_value(input glue_pkg::mgmt_addr_t addr);
		return {addr ^ 16'h5a5a, ~addr};
	endfunction

	// Clock rate in Hz for each speed selection
	function automatic glue_pkg::rate_t rate_hz(input glue_pkg::speed_sel_t s);
		case (s)
			3'd1:    return 32'd100_000_000;
			3'd2:    return 32'd15_000_000;
			3'd3:    return 32'd30_000_000;
			3'd4:    return 32'd56_250_000;
			default: return 32'd90_000_000;
		endcase
	endfunction

	// Framebuffer descriptor from the video mode rules
	function automatic glue_pkg::fb_desc_t fb_ref(input glue_pkg::vga_mode_t m,
			input logic rgb, input logic f565);
		glue_pkg::fb_desc_t d;
		d.en = !m.flags[2] && (m.flags[1:0] != 2'd0);
		d.base = {glue_pkg::FB_BASE_PREFIX, m.start_addr, 2'b00};
		if (m.flags[1:0] == 2'd3)
			d.width = 12'd640;
		else if (m.flags[2])
			d.width = 12'(m.width) * 12'd4;
		else
			d.width = 12'(m.width) * 12'd8;
		d.stride = 14'(m.stride) * 14'd8;
		d.height = m.flags[3] ? 12'(m.height) / 12'd2 : 12'(m.height);
		case (m.flags[1:0])
			2'd3:    d.format = {~rgb, ~f565, 3'd5};
			2'd2:    d.format = {~rgb, ~f565, 3'd4};
			default: d.format = {~rgb, ~f565, 3'd3};
		endcase
		d.force_blank = 1'b0;
		return d;
	endfunction

	// ============================================================
	// Concurrent checks
	// ============================================================
	a_strobe_hold: assert property (@(posedge clk_sys) disable iff (RESET)
		((bus_rd || bus_wr) && bus_wait) |=> (bus_rd || bus_wr))
	else begin
		$display("Error bus strobe dropped under bus_wait, bus_rd %h bus_wr %h",
			$sampled(bus_rd), $sampled(bus_wr));
		err_cnt++;
	end

	a_ready_low: assert property (@(posedge clk_sys) disable iff (RESET)
		(bus_rd || bus_wr) |-> !host_cmd_ready)
	else begin
		$display("Error host_cmd_ready %h during open transfer", $sampled(host_cmd_ready));
		err_cnt++;
	end

	a_bus_cmd: assert property (@(posedge clk_sys) disable iff (RESET)
		(bus_rd || bus_wr) |-> (bus_addr == exp_addr && (bus_rd || bus_wdata == exp_wdata)))
	else begin
		$display("Error bus_addr %h exp %h bus_wdata %h exp %h",
			$sampled(bus_addr), exp_addr, $sampled(bus_wdata), exp_wdata);
		err_cnt++;
	end

	a_seq_done: assert property (@(posedge clk_sys) disable iff (RESET)
		(cfg_write && !cfg_wait && cfg_addr == glue_pkg::CFG_ADDR_START) |=> !seq_busy)
	else begin
		$display("Error seq_busy %h after last config write", $sampled(seq_busy));
		err_cnt++;
	end

`endif

// File: tb_glue_top.sv
/* Testbench for the ao486 platform glue
   Bus and config port models with directed and LFSR driven stimulus */
module tb_glue_top;

	localparam int TIMEOUT = 300;

	logic clk_sys, RESET, host_cmd_valid, host_cmd_ready, rsp_valid;
	logic bus_rd, bus_wr, bus_wait, bus_rdvalid, host_reset, user_button, kbc_reset_n;
	logic sys_reset, cpu_reset, uart_fast, cfg_wait, cfg_write, seq_busy;
	logic rgb_order, fmt_565, led_hdd, led_fdd;
	logic [7:0]           disk_req;
	glue_pkg::host_cmd_t  host_cmd;
	glue_pkg::mgmt_data_t rsp_data, bus_wdata, bus_rdata;
	glue_pkg::mgmt_addr_t bus_addr;
	glue_pkg::speed_sel_t speed;
	glue_pkg::cfg_addr_t  cfg_addr;
	glue_pkg::cfg_data_t  cfg_data;
	glue_pkg::rate_t      cur_rate;
	glue_pkg::vga_mode_t  vga_mode;
	glue_pkg::fb_desc_t   fb_desc;
	logic [31:0]          lfsr = 32'hbefe;
	glue_pkg::cfg_addr_t  cfg_addr_log[$];
	glue_pkg::cfg_data_t  cfg_data_log[$];

	`include "tb_glue_checks.svh"

	ao486_glue_top #(.LED_HOLD(12)) UUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[62:0], lfsr[0]};
		end
		return v;
	endfunction

	// Bus and config port models with random stalls
	always @(posedge clk_sys) begin
		bus_wait    <= 1'(rand_bits(1));
		cfg_wait    <= 1'(rand_bits(1));
		bus_rdvalid <= bus_rd && !bus_wait;
		if (bus_rd && !bus_wait)
			bus_rdata <= rd_value(bus_addr);
		if (cfg_write && !cfg_wait) begin
			cfg_addr_log.push_back(cfg_addr);
			cfg_data_log.push_back(cfg_data);
		end
	end

	task automatic check_equal(input string name, input logic [127:0] got, input logic [127:0] exp);
		assert (got === exp)
		else begin
			$display("Error %s got %h expected %h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic note_timeout(input string what);
		$display("Timed out waiting for %s", what);
		err_cnt++;
	endtask

	task automatic end_test(input string name, input int err0);
		test_cnt++;
		$display("Test %s: %s", name, (err_cnt == err0) ? "ok" : "failed");
	endtask

	task automatic sequence_resets();
		int n;
		int err0;
		err0 = err_cnt;
		// System reset holds until the first host reset edge
		repeat (16) begin
			@(posedge clk_sys);
			check_equal("sys_reset", sys_reset, 1);
		end
		host_reset <= 1'b1;
		n = 0;
		while (sys_reset && n < TIMEOUT) begin
			@(posedge clk_sys);
			n++;
		end
		if (n == TIMEOUT)
			note_timeout("sys_reset release");
		host_reset <= 1'b0;
		repeat (4) @(posedge clk_sys);
		host_reset <= 1'b1;
		n = 0;
		while (!sys_reset && n < TIMEOUT) begin
			@(posedge clk_sys);
			n++;
		end
		if (n == TIMEOUT)
			note_timeout("sys_reset pulse");
		n = 0;
		while (sys_reset && n < TIMEOUT) begin
			@(posedge clk_sys);
			n++;
		end
		check_equal("sys_reset high cycles", n, glue_pkg::RESET_PULSE_LEN);
		host_reset <= 1'b0;
		n = 0;
		while (cpu_reset && n < TIMEOUT) begin
			@(posedge clk_sys);
			n++;
		end
		if (n == TIMEOUT)
			note_timeout("cpu_reset release");
		user_button <= 1'b1;
		@(posedge clk_sys);
		user_button <= 1'b0;
		n = 0;
		while (!cpu_reset && n < TIMEOUT) begin
			@(posedge clk_sys);
			check_equal("sys_reset", sys_reset, 0);
			n++;
		end
		if (n == TIMEOUT)
			note_timeout("cpu_reset from user_button");
		end_test("reset", err0);
	endtask

	task automatic exercise_bridge();
		int n;
		int err0;
		glue_pkg::host_cmd_t cmd;
		err0 = err_cnt;
		for (int i = 0; i < 16; i++) begin
			cmd.rd = 1'(rand_bits(1));
			cmd.wr = !cmd.rd;
			cmd.addr = 16'(rand_bits(16));
			cmd.data = 32'(rand_bits(32));
			exp_addr = cmd.addr;
			exp_wdata = cmd.data;
			@(posedge clk_sys);
			host_cmd <= cmd;
			host_cmd_valid <= 1'b1;
			@(posedge clk_sys);
			host_cmd_valid <= 1'b0;
			n = 0;
			while (!rsp_valid && n < TIMEOUT) begin
				@(posedge clk_sys);
				n++;
			end
			if (n == TIMEOUT)
				note_timeout("bridge response");
			else if (cmd.rd)
				check_equal("rsp_data", rsp_data, rd_value(cmd.addr));
		end
		end_test("bridge", err0);
	endtask

	task automatic apply_speed(input glue_pkg::speed_sel_t s, input logic uf);
		int n;
		glue_pkg::cfg_addr_t exp_a[4];
		glue_pkg::cfg_data_t exp_d[4];
		exp_a = '{glue_pkg::CFG_ADDR_MODE, glue_pkg::CFG_ADDR_COUNTER,
			glue_pkg::CFG_ADDR_COUNTER, glue_pkg::CFG_ADDR_START};
		exp_d = '{32'd0, glue_pkg::SPEED_DIV_TABLE[s],
			uf ? glue_pkg::UART_DIV_FAST : glue_pkg::UART_DIV_NORMAL, 32'd0};
		cfg_addr_log.delete();
		cfg_data_log.delete();
		@(posedge clk_sys);
		speed <= s;
		uart_fast <= uf;
		n = 0;
		while (!seq_busy && n < TIMEOUT) begin
			@(posedge clk_sys);
			n++;
		end
		if (n == TIMEOUT)
			note_timeout("speed sequence start");
		n = 0;
		while (seq_busy && n < TIMEOUT) begin
			@(posedge clk_sys);
			n++;
		end
		if (n == TIMEOUT)
			note_timeout("speed sequence end");
		repeat (2) @(posedge clk_sys);
		check_equal("config write count", cfg_addr_log.size(), 4);
		for (int i = 0; i < 4 && i < cfg_addr_log.size(); i++) begin
			check_equal("cfg_addr", cfg_addr_log[i], exp_a[i]);
			check_equal("cfg_data", cfg_data_log[i], exp_d[i]);
		end
		check_equal("cur_rate", cur_rate, rate_hz(s));
	endtask

	task automatic change_speeds();
		int err0;
		err0 = err_cnt;
		apply_speed(3'd3, 1'b0);
		apply_speed(3'd3, 1'b1);
		apply_speed(3'd4, 1'b1);
		end_test("speed", err0);
	endtask

	task automatic sweep_fb_modes();
		int err0;
		glue_pkg::vga_mode_t m;
		logic rgb;
		logic f565;
		err0 = err_cnt;
		for (int i = 0; i < 32; i++) begin
			m = 54'(rand_bits(54));
			rgb = 1'(rand_bits(1));
			f565 = 1'(rand_bits(1));
			@(posedge clk_sys);
			vga_mode <= m;
			rgb_order <= rgb;
			fmt_565 <= f565;
			repeat (2) @(posedge clk_sys);
			check_equal("fb_desc", fb_desc, fb_ref(m, rgb, f565));
		end
		end_test("framebuffer", err0);
	endtask

	task automatic pulse_disk_req(input logic [7:0] mask, input logic hdd);
		int n;
		@(posedge clk_sys);
		disk_req <= mask;
		@(posedge clk_sys);
		disk_req <= 8'h00;
		n = 0;
		while (!(hdd ? led_hdd : led_fdd) && n < TIMEOUT) begin
			@(posedge clk_sys);
			n++;
		end
		if (n == TIMEOUT)
			note_timeout("activity light");
		n = 0;
		while ((hdd ? led_hdd : led_fdd) && n < TIMEOUT) begin
			check_equal(hdd ? "led_fdd" : "led_hdd", hdd ? led_fdd : led_hdd, 0);
			@(posedge clk_sys);
			n++;
		end
		check_equal("led on cycles", n, 12);
	endtask

	task automatic flash_lights();
		int err0;
		err0 = err_cnt;
		pulse_disk_req(8'h04, 1'b1);
		pulse_disk_req(8'h80, 1'b0);
		end_test("lights", err0);
	endtask

	initial begin
		RESET = 1'b1;
		host_cmd = '0;
		host_cmd_valid = 1'b0;
		bus_wait = 1'b0;
		bus_rdvalid = 1'b0;
		bus_rdata = '0;
		host_reset = 1'b0;
		user_button = 1'b0;
		kbc_reset_n = 1'b1;
		speed = '0;
		uart_fast = 1'b0;
		cfg_wait = 1'b0;
		vga_mode = '0;
		rgb_order = 1'b0;
		fmt_565 = 1'b0;
		disk_req = '0;
		repeat (5) @(posedge clk_sys);
		RESET <= 1'b0;
		sequence_resets();
		exercise_bridge();
		change_speeds();
		sweep_fb_modes();
		flash_lights();
		$display("Tests run %0d, errors %0d", test_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// File: list.f
+incdir+.
glue_pkg.sv
host_mgmt_bridge.sv
reset_ctrl.sv
clk_speed_seq.sv
fb_desc_gen.sv
activity_led.sv
ao486_glue_top.sv
tb_glue_top.sv
